// File: dv/heapVectors.svh
// Vector table of the heap testbench
// Requests with their expected dataOut and error
// Columns are op, array, index, data, dataOut, error, count, step and model flag

task automatic loadVectors();
  // Allocation order and reuse of a freed array
  addRows(alloc, 0, 0, 0, 'h0000, none, 3, 1);
  addRows(free, 1, 0, 0, 'h0001);
  addRows(alloc, 0, 0, 0, 'h0001);
  addRows(read, 5, 0, 0, 'h0001, notAllocated);     // Never allocated so the word is held
  addRows(free, 5, 0, 0, 'h0001, notAllocated);     // Free of an unused array
  // Write, read, size and resize on array 0
  addRows(write, 0, 0, 'h0011, 'h0011, none, 3, 1);
  addRows(size, 0, 0, 0, 'h0003);
  addRows(read, 0, 0, 0, 'h0011, none, 3, 1);
  addRows(read, 0, 3, 0, 'h0013, outOfBounds);
  addRows(resize, 0, 0, 9, 'h0013, tooLarge);
  addRows(resize, 0, 0, 2, 'h0002);
  addRows(read, 0, 2, 0, 'h0002, outOfBounds);      // Cut off by the resize
  // Array 1 as a stack
  addRows(push, 1, 0, 'h0101, 'h0101, none, 8, 1);
  addRows(push, 1, 0, 'h0109, 'h0108, full);
  addRows(pop, 1, 0, 0, 'h0108, none, 8, -1);       // Reverse order
  addRows(pop, 1, 0, 0, 'h0101, empty);
  // Insert and remove on array 2
  addRows(write, 2, 0, 0, 'h0000, none, 3, 1);
  addRows(up, 2, 2, 99, 99);
  addRows(read, 2, 0, 0, 'h0000, none, 2, 1);
  addRows(read, 2, 2, 0, 99);
  addRows(read, 2, 3, 0, 'h0002);                   // Shifted up
  addRows(down, 2, 1, 0, 'h0001);
  addRows(read, 2, 0, 0, 'h0000);
  addRows(read, 2, 1, 0, 99);
  addRows(read, 2, 2, 0, 'h0002);
  addRows(size, 2, 0, 0, 'h0003);
  // Random arithmetic on element 0 of array 0
  addRows(write, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(add, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(subtract, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(orOp, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(xorOp, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(andOp, 0, 0, 0, 0, none, 1, 0, 1'b1);
  addRows(read, 0, 0, 0, 0, none, 1, 0, 1'b1);
  // Access after free, then use up every array
  addRows(free, 2, 0, 0, 'h0002);
  addRows(read, 2, 0, 0, 'h0002, freed);
  addRows(write, 2, 0, 'h0055, 'h0002, freed);
  addRows(free, 2, 0, 0, 'h0002, freed);
  addRows(alloc, 0, 0, 0, 'h0002, none, 6, 1);      // Freed array first
  addRows(alloc, 0, 0, 0, 'h0007, outOfMemory);
endtask

// File: dv/heapMemoryTb.sv
// Testbench of the array heap
// Vector table, xorshift data for the arithmetic rows and response checks
`default_nettype none

module heapMemoryTb;
  import heapPkg::*;

  typedef struct packed {
    heapRequest          req;
    logic [dataBits-1:0] expData;
    heapError            expError;
    logic                fromModel;                  // Data drawn and expected word modelled
  } vectorRow;

  localparam int resetCycles  = 16;
  localparam int settleCycles = 20;                  // Timeout for outputs after reset

  logic                clock = 1'b0;
  logic                reset;
  heapRequest          req;
  logic [dataBits-1:0] dataOut;
  heapError            error;
  vectorRow            rows [$];                     // Expanded table
  logic [31:0]         rngState = 32'd41;            // xorshift seed
  logic [dataBits-1:0] model;                        // Element under random arithmetic

  heapMemory uut (.*);

  always #20 clock = ~clock;                         // Period 40

  // ----------------------------------------
  // Reference model
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    return y ^ (y << 5);
  endfunction

  function automatic logic [dataBits-1:0] nextValue(input heapOp op,
                                                    input logic [dataBits-1:0] old,
                                                    input logic [dataBits-1:0] operand);
    case (op)
      write:    return operand;
      add:      return old + operand;                // Wraps to 16 bits
      subtract: return old - operand;
      orOp:     return old | operand;
      xorOp:    return old ^ operand;
      andOp:    return old & operand;
      default:  return old;                          // Read leaves the element
    endcase
  endfunction

  // Queues count rows that step index, data and expected word
  task automatic addRows(input heapOp op, input int array, input int index, input int data,
                         input int expData, input heapError expError = none,
                         input int count = 1, input int step = 0, input bit fromModel = 1'b0);
    vectorRow r;
    for (int k = 0; k < count; k++) begin
      r.req.op    = op;
      r.req.array = addressBits'(array);
      r.req.index = indexBits'(index + k * step);
      r.req.data  = dataBits'(data + k * step);
      r.expData   = dataBits'(expData + k * step);
      r.expError  = expError;
      r.fromModel = fromModel;
      rows.push_back(r);
    end
  endtask

  `include "heapVectors.svh"

  // ----------------------------------------
  // Stimulus and checks
  // ----------------------------------------
  initial begin
    vectorRow row;
    int       waited;
    reset = 1'b1;
    req   = '0;
    model = '0;
    loadVectors();
    repeat (resetCycles) @(posedge clock);
    #2;
    reset  = 1'b0;
    waited = 0;
    while (dataOut !== '0 || error !== none) begin   // Cleared outputs after reset
      if (waited == settleCycles) begin
        $display("Outputs were not cleared by reset");
        $display("Test failed");
        $fatal(1);
      end
      @(posedge clock);
      #2;
      waited++;
    end
    foreach (rows[n]) begin
      row = rows[n];
      if (row.fromModel) begin
        rngState     = xorshift(rngState);
        row.req.data = rngState[dataBits-1:0];
        model        = nextValue(row.req.op, model, row.req.data);
        row.expData  = model;
      end
      req = row.req;                                 // Just after the edge
      @(posedge clock);
      #2;
      assert (error === row.expError) else begin
        $display("** Error: error = 0x%h, expected 0x%h in row %0d", error, row.expError, n);
        $display("Test failed");
        $fatal(1);
      end
      assert (dataOut === row.expData) else begin
        $display("** Error: dataOut = 0x%h, expected 0x%h in row %0d", dataOut, row.expData, n);
        $display("Test failed");
        $fatal(1);
      end
    end
    $display("Test passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: logic/arrayAllocator.sv
// Array allocator
// High-water mark, stack of freed arrays and allocation bits
`default_nettype none

module arrayAllocator
  import heapPkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire heapRequest req,
  input  wire logic       commitAlloc,               // Take the granted array
  input  wire logic       commitFree,                // Release req.array
  output allocStatus      status
);

  logic [addressBits:0]   highWater;                 // Arrays ever handed out, up to arrayCount
  logic [addressBits:0]   stackTop;                  // Entries on the freed stack
  logic [addressBits:0]   topLess;                   // Index of the top entry
  logic [arrayCount-1:0]  allocated;                 // One bit per array in use
  logic [addressBits-1:0] freedStack [arrayCount];   // Freed array numbers
  logic                   stackEmpty;
  logic                   neverUsed;                 // Requested array above the mark

  assign topLess    = stackTop - 1'b1;
  assign stackEmpty = (stackTop == '0);
  assign neverUsed  = ({1'b0, req.array} >= highWater);

  // ----------------------------------------
  // Status for the size tracker
  // ----------------------------------------
  assign status.live       = allocated[req.array];
  assign status.reason     = neverUsed ? notAllocated : freed;
  assign status.granted    = !stackEmpty || !highWater[addressBits]; // MSB set means all used
  assign status.grantArray = stackEmpty ? highWater[addressBits-1:0] // Reuse freed arrays first
                                        : freedStack[topLess[addressBits-1:0]];

  // ----------------------------------------
  // State updates
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      highWater <= '0;
      stackTop  <= '0;
      allocated <= '0;
    end else if (commitAlloc) begin
      allocated[status.grantArray] <= 1'b1;
      if (!stackEmpty) begin
        stackTop <= topLess;                         // Pop the freed stack
      end else begin
        highWater <= highWater + 1'b1;               // Fresh array
      end
    end else if (commitFree) begin
      allocated[req.array] <= 1'b0;
      stackTop             <= stackTop + 1'b1;
    end
  end

  // Only live arrays are freed, so the stack never overflows
  always_ff @(posedge clock) begin
    if (commitFree) begin
      freedStack[stackTop[addressBits-1:0]] <= req.array;
    end
  end

endmodule

`default_nettype wire

// File: logic/arrayStore.sv
// Element memory of the heap
// Writes, shifts, element arithmetic and the registered response
`default_nettype none

module arrayStore
  import heapPkg::*;
(
  input  wire logic        clock,
  input  wire logic        reset,
  input  wire storeCommand cmd,
  output logic [dataBits-1:0] dataOut,               // Output word of the last request
  output heapError         error                     // Error of the last request
);

  logic [dataBits-1:0]  mem [arrayCount][arrayLength]; // Fixed block per array
  logic [dataBits-1:0]  row [arrayLength];           // Addressed array
  logic [dataBits-1:0]  upRow [arrayLength];         // Row after an insert
  logic [dataBits-1:0]  downRow [arrayLength];       // Row after a removal
  logic [dataBits-1:0]  element;                     // Addressed element
  logic [dataBits-1:0]  arith;                       // New element value
  logic [indexBits-1:0] tailIndex;                   // First free slot
  logic [indexBits-1:0] lastIndex;                   // Last used slot
  logic                 isRequest;
  logic                 accept;                      // Request passed the checks

  assign row       = mem[cmd.array];
  assign element   = row[cmd.index];
  assign tailIndex = cmd.size[indexBits-1:0];
  assign lastIndex = tailIndex - 1'b1;               // Wraps to the top slot when full
  assign isRequest = cmd.op inside {[write:andOp]};
  assign accept    = isRequest && (cmd.error == none);

  // ----------------------------------------
  // Datapath
  // ----------------------------------------
  always_comb begin
    case (cmd.op)
      add:      arith = element + cmd.data;          // Wraps to dataBits
      subtract: arith = element - cmd.data;
      orOp:     arith = element | cmd.data;
      xorOp:    arith = element ^ cmd.data;
      default:  arith = element & cmd.data;
    endcase
  end

  always_comb begin
    for (int i = 0; i < arrayLength; i++) begin
      upRow[i]   = row[i];
      downRow[i] = row[i];
      if (i > cmd.index && i <= cmd.size) begin
        upRow[i] = row[i-1];                         // Open a gap at index
      end
      if (i >= cmd.index && i < arrayLength - 1) begin
        downRow[i] = row[i+1];                       // Close the gap at index
      end
    end
    upRow[cmd.index] = cmd.data;
  end

  // ----------------------------------------
  // Element memory
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (accept) begin
      case (cmd.op)
        write:                          mem[cmd.array][cmd.index] <= cmd.data;
        push:                           mem[cmd.array][tailIndex] <= cmd.data;
        up:                             mem[cmd.array]            <= upRow;
        down:                           mem[cmd.array]            <= downRow;
        add, subtract, orOp, xorOp, andOp: mem[cmd.array][cmd.index] <= arith;
        default: begin                               // No element change
        end
      endcase
    end
  end

  // ----------------------------------------
  // Response registers
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      dataOut <= '0;
      error   <= none;
    end else if (isRequest) begin
      error <= cmd.error;                            // Output word held on error
      if (cmd.error == none) begin
        case (cmd.op)
          write, push, up: dataOut <= cmd.data;
          read, down:      dataOut <= element;       // Down returns the removed element
          pop:             dataOut <= row[lastIndex];
          size, resize:    dataOut <= dataBits'(cmd.newSize);
          alloc, free:     dataOut <= dataBits'(cmd.array);
          default:         dataOut <= arith;         // Element arithmetic
        endcase
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/heapMemory.sv
// Top level of the array heap
// Allocator, size tracker and element store
`default_nettype none

module heapMemory
  import heapPkg::*;
(
  input  wire logic                clock,
  input  wire logic                reset,
  input  wire heapRequest          req,              // One request per cycle, nop when idle
  output logic [dataBits-1:0]      dataOut,          // Registered output word
  output heapError                 error             // Registered error code
);

  allocStatus  status;                               // Liveness and next grant
  storeCommand cmd;                                  // Checked and resolved request
  logic        commitAlloc;                          // Alloc passed the checks
  logic        commitFree;                           // Free passed the checks

  // ----------------------------------------
  // Array bookkeeping
  // ----------------------------------------
  arrayAllocator allocator (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .commitAlloc (commitAlloc),
    .commitFree  (commitFree),
    .status      (status)
  );

  sizeTracker tracker (
    .clock       (clock),
    .reset       (reset),
    .req         (req),
    .status      (status),
    .commitAlloc (commitAlloc),
    .commitFree  (commitFree),
    .cmd         (cmd)
  );

  // ----------------------------------------
  // Elements and response
  // ----------------------------------------
  arrayStore store (
    .clock   (clock),
    .reset   (reset),
    .cmd     (cmd),
    .dataOut (dataOut),
    .error   (error)
  );

endmodule

`default_nettype wire

// File: logic/heapPkg.sv
// Shared widths of the array heap
// Opcode and error code enums
// Request, allocator status and store command structs
`default_nettype none

package heapPkg;

  // ----------------------------------------
  // Widths and sizes
  // ----------------------------------------
  localparam int addressBits = 3;                    // Bits in an array number
  localparam int indexBits   = 3;                    // Bits in an element index
  localparam int dataBits    = 16;                   // Bits in an element
  localparam int arrayCount  = 1 << addressBits;     // Arrays in the heap
  localparam int arrayLength = 1 << indexBits;       // Elements per array
  localparam int sizeBits    = indexBits + 1;        // Size must reach arrayLength

  // ----------------------------------------
  // Opcodes and error codes
  // ----------------------------------------
  typedef enum logic [4:0] {
    nop, write, read, size, push, pop, resize, up, down,
    alloc, free, add, subtract, orOp, xorOp, andOp
  } heapOp;

  typedef enum logic [3:0] {
    none, notAllocated, freed, outOfBounds, empty, full, tooLarge, outOfMemory
  } heapError;

  // ----------------------------------------
  // Structs between the blocks
  // ----------------------------------------
  typedef struct packed {
    heapOp                  op;                      // Requested operation
    logic [addressBits-1:0] array;                   // Target array
    logic [indexBits-1:0]   index;                   // Element within array
    logic [dataBits-1:0]    data;                    // Input word
  } heapRequest;

  typedef struct packed {
    logic                   live;                    // Requested array is allocated
    heapError               reason;                  // Why it is not
    logic                   granted;                 // An alloc would succeed
    logic [addressBits-1:0] grantArray;              // Array an alloc would get
  } allocStatus;

  typedef struct packed {
    heapOp                  op;
    logic [addressBits-1:0] array;                   // Resolved array, granted one on alloc
    logic [indexBits-1:0]   index;
    logic [dataBits-1:0]    data;
    logic [sizeBits-1:0]    size;                    // Size before the request
    logic [sizeBits-1:0]    newSize;                 // Size after the request
    heapError               error;                   // Result of the checks
  } storeCommand;

endpackage

`default_nettype wire

// File: logic/sizeTracker.sv
// Size table of the arrays
// Checks every request and resolves it into a store command
`default_nettype none

module sizeTracker
  import heapPkg::*;
(
  input  wire logic       clock,
  input  wire logic       reset,
  input  wire heapRequest req,
  input  wire allocStatus status,
  output logic            commitAlloc,               // Alloc accepted this cycle
  output logic            commitFree,                // Free accepted this cycle
  output storeCommand     cmd
);

  localparam logic [sizeBits-1:0] fullSize  = sizeBits'(arrayLength);
  localparam logic [dataBits-1:0] sizeLimit = dataBits'(arrayLength);

  logic [sizeBits-1:0] sizes [arrayCount];           // Current size of each array
  logic [sizeBits-1:0] curSize;                      // Size of the requested array
  logic [sizeBits-1:0] wideIndex;                    // Index widened to a size
  logic                isRequest;                    // Known opcode other than nop
  logic                needsLive;                    // Op works on an existing array

  assign curSize   = sizes[req.array];
  assign wideIndex = {1'b0, req.index};
  assign isRequest = req.op inside {[write:andOp]};
  assign needsLive = isRequest && (req.op != alloc);

  // ----------------------------------------
  // Checks and size rules
  // ----------------------------------------
  always_comb begin
    cmd.op      = req.op;
    cmd.array   = req.array;
    cmd.index   = req.index;
    cmd.data    = req.data;
    cmd.size    = curSize;
    cmd.newSize = curSize;                           // Most ops keep the size
    cmd.error   = none;

    if (needsLive && !status.live) begin
      cmd.error = status.reason;                     // Never allocated or freed
    end else begin
      case (req.op)
        write: begin
          if (wideIndex >= curSize) begin
            cmd.newSize = wideIndex + 1'b1;          // Grow to cover the index
          end
        end
        read, add, subtract, orOp, xorOp, andOp: begin
          if (wideIndex >= curSize) begin
            cmd.error = outOfBounds;
          end
        end
        push: begin
          if (curSize == fullSize) begin
            cmd.error = full;
          end else begin
            cmd.newSize = curSize + 1'b1;
          end
        end
        pop, down: begin
          if (curSize == '0) begin
            cmd.error = empty;
          end else begin
            cmd.newSize = curSize - 1'b1;
          end
        end
        resize: begin
          if (req.data > sizeLimit) begin
            cmd.error = tooLarge;
          end else begin
            cmd.newSize = req.data[sizeBits-1:0];
          end
        end
        up: begin
          if (curSize != fullSize) begin
            cmd.newSize = curSize + 1'b1;            // Full array drops its last element
          end
        end
        alloc: begin
          if (!status.granted) begin
            cmd.error = outOfMemory;
          end else begin
            cmd.array   = status.grantArray;         // Resolve to the granted array
            cmd.size    = '0;
            cmd.newSize = '0;                        // Fresh array starts empty
          end
        end
        default: begin                               // size, free, nop
        end
      endcase
    end
  end

  assign commitAlloc = (req.op == alloc) && (cmd.error == none);
  assign commitFree  = (req.op == free) && (cmd.error == none);

  // ----------------------------------------
  // Size table update
  // ----------------------------------------
  always_ff @(posedge clock) begin
    if (reset) begin
      sizes <= '{default: '0};
    end else if (isRequest && cmd.error == none) begin
      sizes[cmd.array] <= cmd.newSize;
    end
  end

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Builds the heap testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module heapMemoryTb \
  -f verilog.f -o heapSim

if ./obj_dir/heapSim | tee /dev/stderr | grep -x "Test passed" > /dev/null; then
  exit 0
fi
exit 1

// File: verilog.f
+incdir+dv
logic/heapPkg.sv
logic/arrayAllocator.sv
logic/sizeTracker.sv
logic/arrayStore.sv
logic/heapMemory.sv
dv/heapMemoryTb.sv
